//--- logic/epu_pkg.sv
// Fixed vectors and identity words; PSR flag bits 3..0 are not implemented and read as zero
`default_nettype none

package epu_pkg;

   localparam int DW          = 32;
   localparam int AW          = 32;
   localparam int PC_W        = AW - 2;
   localparam int PSR_W       = 10;
   localparam int MSR_BANK_AW = 4;
   localparam int MSR_OFF_AW  = 9;
   localparam int SR_NUM      = 4;

   // Bank codes, address bits 12..9
   localparam logic [MSR_BANK_AW-1:0] BANK_PS = 4'd0;
   localparam logic [MSR_BANK_AW-1:0] BANK_SR = 4'd8;

   // One-hot offset bits inside the PS bank
   localparam int OFF_PSR    = 0;
   localparam int OFF_CPUID  = 1;
   localparam int OFF_EPSR   = 2;
   localparam int OFF_EPC    = 3;
   localparam int OFF_ELSA   = 4;
   localparam int OFF_COREID = 5;

   localparam logic [DW-1:0] CPUID_VAL  = 32'h0001_0a21;
   localparam logic [DW-1:0] COREID_VAL = 32'h0000_0003;

   localparam logic [AW-1:0] VEC_ESYSCALL = 32'h0000_0100;
   localparam logic [AW-1:0] VEC_EINSN    = 32'h0000_0200;
   localparam logic [AW-1:0] VEC_EIRQ     = 32'h0000_0300;
   localparam logic [AW-1:0] VEC_EALIGN   = 32'h0000_0400;

   // Only rm set out of reset
   localparam logic [PSR_W-1:0] PSR_RST = 10'h010;

   typedef struct packed {
      logic rmsr;
      logic wmsr;
      logic eret;
      logic esyscall;
      logic einsn;
      logic eirq;
   } epu_opc_t;

   typedef struct packed {
      logic            valid;
      logic [PC_W-1:0] pc;
      logic [PC_W-1:0] npc;
      epu_opc_t        opc;
      logic [DW-1:0]   operand1;
      logic [DW-1:0]   operand2;
      logic [DW-1:0]   imm;
   } ex_req_t;

   typedef union packed {
      logic [DW-1:0] raw;
      struct packed {
         logic [DW-MSR_BANK_AW-MSR_OFF_AW-1:0] upper;
         logic [MSR_BANK_AW-1:0]               bank;
         logic [MSR_OFF_AW-1:0]                off;
      } f;
   } msr_addr_u;

   typedef union packed {
      logic [DW-1:0] raw;
      struct packed {
         logic [DW-PSR_W-1:0] pad;
         logic                dce;
         logic                ice;
         logic                dmme;
         logic                imme;
         logic                ire;
         logic                rm;
         logic [3:0]          flags;
      } f;
   } psr_data_u;

   typedef struct packed {
      logic              eret;
      logic              esyscall;
      logic              einsn;
      logic              eirq;
      logic              psr_refetch;
      logic              we_psr;
      logic              we_epc;
      logic              we_epsr;
      logic              we_elsa;
      logic              we_sr;
      logic [SR_NUM-1:0] sr_off;
      psr_data_u         wdat;
      logic [PC_W-1:0]   epc;
      logic [PC_W-1:0]   npc;
   } epu_commit_t;

   typedef struct packed {
      logic              exc_ent;
      logic              psr_we;
      psr_data_u         psr_nxt;
      logic              epsr_we;
      psr_data_u         epsr_nxt;
      logic              epc_we;
      logic [DW-1:0]     epc_nxt;
      logic              elsa_we;
      logic [DW-1:0]     elsa_nxt;
      logic [SR_NUM-1:0] sr_we;
      logic [DW-1:0]     sr_nxt;
   } msr_write_t;

   typedef struct packed {
      psr_data_u                 psr;
      psr_data_u                 epsr;
      logic [DW-1:0]             epc;
      logic [DW-1:0]             elsa;
      logic [SR_NUM-1:0][DW-1:0] sr;
   } msr_state_t;

endpackage

`default_nettype wire

//--- logic/epu_stage1.sv
// MSR reads return in the same cycle; banks other than PS and SR read as zero and ignore writes
`timescale 1ns/1ps
`default_nettype none

module epu_stage1
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    flush_s1,
   input  logic                    p_ce_s1,
   input  epu_pkg::ex_req_t        ex,
   input  epu_pkg::msr_state_t     state,
   output logic [epu_pkg::DW-1:0]  epu_dout,
   output logic                    epu_dout_valid,
   output epu_pkg::epu_commit_t    commit
);
   import epu_pkg::*;

   msr_addr_u     addr;
   logic          live;
   logic          bank_ps;
   logic          bank_sr;
   logic          wmsr_ps;
   logic [DW-1:0] dout_ps;
   logic [DW-1:0] dout_sr;
   epu_commit_t   commit_d;

   // Base from operand one, low 15 bits from the immediate
   assign addr.raw = ex.operand1 | {{(DW-15){1'b0}}, ex.imm[14:0]};

   assign bank_ps = (addr.f.bank == BANK_PS);
   assign bank_sr = (addr.f.bank == BANK_SR);

   // Instruction still alive in this slot
   assign live = ex.valid & ~flush_s1;

   assign dout_ps =
      ({DW{addr.f.off[OFF_PSR]}}    & state.psr.raw) |
      ({DW{addr.f.off[OFF_CPUID]}}  & CPUID_VAL) |
      ({DW{addr.f.off[OFF_EPSR]}}   & state.epsr.raw) |
      ({DW{addr.f.off[OFF_EPC]}}    & state.epc) |
      ({DW{addr.f.off[OFF_ELSA]}}   & state.elsa) |
      ({DW{addr.f.off[OFF_COREID]}} & COREID_VAL);

   // Lowest set offset bit wins
   always_comb
   begin
      dout_sr = '0;
      for (int i = SR_NUM - 1; i >= 0; i--)
      begin
         if (addr.f.off[i])
            dout_sr = state.sr[i];
      end
   end

   assign epu_dout = ({DW{bank_ps}} & dout_ps) | ({DW{bank_sr}} & dout_sr);
   assign epu_dout_valid = live & ex.opc.rmsr;

   assign wmsr_ps = live & ex.opc.wmsr & bank_ps;

   always_comb
   begin
      commit_d             = '0;
      commit_d.eret        = live & ex.opc.eret;
      commit_d.esyscall    = live & ex.opc.esyscall;
      commit_d.einsn       = live & ex.opc.einsn;
      commit_d.eirq        = live & ex.opc.eirq;
      commit_d.we_psr      = wmsr_ps & addr.f.off[OFF_PSR];
      commit_d.we_epc      = wmsr_ps & addr.f.off[OFF_EPC];
      commit_d.we_epsr     = wmsr_ps & addr.f.off[OFF_EPSR];
      commit_d.we_elsa     = wmsr_ps & addr.f.off[OFF_ELSA];
      commit_d.we_sr       = live & ex.opc.wmsr & bank_sr;
      // New PSR mode bits take effect from a refetch of the next insn
      commit_d.psr_refetch = commit_d.we_psr;
      commit_d.sr_off      = addr.f.off[SR_NUM-1:0];
      commit_d.wdat.raw    = ex.operand2;
      commit_d.epc         = ex.pc;
      commit_d.npc         = ex.npc;
   end

   // A flush loads an empty entry, back-pressure holds the old one
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         commit.eret        <= 1'b0;
         commit.esyscall    <= 1'b0;
         commit.einsn       <= 1'b0;
         commit.eirq        <= 1'b0;
         commit.psr_refetch <= 1'b0;
         commit.we_psr      <= 1'b0;
         commit.we_epc      <= 1'b0;
         commit.we_epsr     <= 1'b0;
         commit.we_elsa     <= 1'b0;
         commit.we_sr       <= 1'b0;
      end
      else if (p_ce_s1 | flush_s1)
      begin
         commit <= commit_d;
      end
   end

   // Decode upstream must never issue two EPU operations at once
   a_opc_onehot: assert property (
      @(posedge clk) disable iff (reset)
      ex.valid |-> $onehot0(ex.opc)
   );

endmodule

`default_nettype wire

//--- logic/epu_commit.sv
// Combinational commit of the held entry; expects at most one flush cause per cycle
`timescale 1ns/1ps
`default_nettype none

module epu_commit
(
   input  logic                      clk,
   input  logic                      reset,
   input  epu_pkg::epu_commit_t      commit,
   input  epu_pkg::msr_state_t       state,
   input  logic                      s2i_ealign,
   input  logic                      p_ce_s2,
   input  logic [epu_pkg::AW-1:0]    s2i_vaddr,
   output epu_pkg::msr_write_t       wr,
   output logic                      exc_flush,
   output logic [epu_pkg::PC_W-1:0]  exc_flush_tgt
);
   import epu_pkg::*;

   logic exc_ent;
   logic exc_ent_q;
   logic save_psr;
   logic set_elsa;

   // ERET leaves exception mode, so it is not an entry
   assign exc_ent  = commit.esyscall | commit.einsn | commit.eirq | s2i_ealign;
   assign save_psr = exc_ent & ~exc_ent_q;
   assign set_elsa = commit.einsn | s2i_ealign;

   always_ff @(posedge clk)
   begin
      if (reset)
         exc_ent_q <= 1'b0;
      else
         exc_ent_q <= exc_ent;
   end

   always_comb
   begin
      wr.exc_ent = exc_ent;

      wr.psr_we  = commit.we_psr | commit.eret;
      wr.psr_nxt = state.psr;
      if (commit.we_psr)
      begin
         wr.psr_nxt = commit.wdat;
      end
      else
      begin
         // Restore mode bits, cache enables stay
         wr.psr_nxt.f.rm   = state.epsr.f.rm;
         wr.psr_nxt.f.ire  = state.epsr.f.ire;
         wr.psr_nxt.f.imme = state.epsr.f.imme;
         wr.psr_nxt.f.dmme = state.epsr.f.dmme;
      end

      // EPSR only takes the PSR on the first cycle of an entry
      wr.epsr_we  = commit.we_epsr | save_psr;
      wr.epsr_nxt = commit.we_epsr ? commit.wdat : state.psr;

      // Syscall returns past itself, other exceptions retry the insn
      wr.epc_we = commit.we_epc | exc_ent;
      if (commit.we_epc)
         wr.epc_nxt = commit.wdat.raw;
      else if (commit.esyscall)
         wr.epc_nxt = {commit.npc, 2'b00};
      else
         wr.epc_nxt = {commit.epc, 2'b00};

      wr.elsa_we = commit.we_elsa | set_elsa;
      if (commit.einsn)
         wr.elsa_nxt = {commit.epc, 2'b00};
      else if (s2i_ealign)
         wr.elsa_nxt = s2i_vaddr;
      else
         wr.elsa_nxt = commit.wdat.raw;

      wr.sr_we  = commit.sr_off & {SR_NUM{commit.we_sr}};
      wr.sr_nxt = commit.wdat.raw;
   end

   assign exc_flush = p_ce_s2 & (commit.eret | commit.esyscall | commit.einsn |
                                 commit.eirq | commit.psr_refetch | s2i_ealign);

   assign exc_flush_tgt =
      ({PC_W{commit.esyscall}}    & VEC_ESYSCALL[2 +: PC_W]) |
      ({PC_W{commit.einsn}}       & VEC_EINSN[2 +: PC_W]) |
      ({PC_W{commit.eirq}}        & VEC_EIRQ[2 +: PC_W]) |
      ({PC_W{s2i_ealign}}         & VEC_EALIGN[2 +: PC_W]) |
      ({PC_W{commit.psr_refetch}} & commit.npc) |
      ({PC_W{commit.eret}}        & state.epc[2 +: PC_W]);

   // Target is an and-or, so two causes would merge vectors
   a_one_cause: assert property (
      @(posedge clk) disable iff (reset)
      $onehot0({commit.eret, commit.esyscall, commit.einsn, commit.eirq,
                commit.psr_refetch, s2i_ealign})
   );

endmodule

`default_nettype wire

//--- logic/epu_msr_file.sv
// PSR keeps bits 9..4 only; EPSR stores the low 10 bits of whatever is written
`timescale 1ns/1ps
`default_nettype none

module epu_msr_file
(
   input  logic                 clk,
   input  logic                 reset,
   input  epu_pkg::msr_write_t  wr,
   output epu_pkg::msr_state_t  state
);
   import epu_pkg::*;

   logic [PSR_W-1:0]          psr_q;
   logic [PSR_W-1:0]          epsr_q;
   logic [DW-1:0]             epc_q;
   logic [DW-1:0]             elsa_q;
   logic [SR_NUM-1:0][DW-1:0] sr_q;
   psr_data_u                 psr_ent;

   // Exception entry forces kernel mode with IRQs and MMUs off
   always_comb
   begin
      psr_ent        = state.psr;
      psr_ent.f.rm   = 1'b1;
      psr_ent.f.ire  = 1'b0;
      psr_ent.f.imme = 1'b0;
      psr_ent.f.dmme = 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         psr_q  <= PSR_RST;
         epsr_q <= '0;
         epc_q  <= '0;
         elsa_q <= '0;
      end
      else
      begin
         // Flags are dropped on write
         if (wr.psr_we)
            psr_q <= {wr.psr_nxt.raw[PSR_W-1:4], 4'b0000};
         else if (wr.exc_ent)
            psr_q <= psr_ent.raw[PSR_W-1:0];
         if (wr.epsr_we)
            epsr_q <= wr.epsr_nxt.raw[PSR_W-1:0];
         if (wr.epc_we)
            epc_q <= wr.epc_nxt;
         if (wr.elsa_we)
            elsa_q <= wr.elsa_nxt;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         sr_q <= '0;
      else
      begin
         for (int i = 0; i < SR_NUM; i++)
         begin
            if (wr.sr_we[i])
               sr_q[i] <= wr.sr_nxt;
         end
      end
   end

   always_comb
   begin
      state.psr.raw  = {{(DW-PSR_W){1'b0}}, psr_q};
      state.epsr.raw = {{(DW-PSR_W){1'b0}}, epsr_q};
      state.epc      = epc_q;
      state.elsa     = elsa_q;
      state.sr       = sr_q;
   end

endmodule

`default_nettype wire

//--- logic/epu_top.sv
// No handshake; p_ce_s1, p_ce_s2, flush_s1 and ex.valid are plain strobes from the pipeline
`timescale 1ns/1ps
`default_nettype none

module epu_top
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      flush_s1,
   input  logic                      p_ce_s1,
   input  logic                      p_ce_s2,
   input  epu_pkg::ex_req_t          ex,
   input  logic                      s2i_ealign,
   input  logic [epu_pkg::AW-1:0]    s2i_vaddr,
   output logic [epu_pkg::DW-1:0]    epu_dout,
   output logic                      epu_dout_valid,
   output logic                      exc_flush,
   output logic [epu_pkg::PC_W-1:0]  exc_flush_tgt
);
   import epu_pkg::*;

   epu_commit_t commit;
   msr_write_t  wr;
   msr_state_t  state;

   // Decode, read and commit entry
   epu_stage1 u_stage1
   (
      .clk            (clk),
      .reset          (reset),
      .flush_s1       (flush_s1),
      .p_ce_s1        (p_ce_s1),
      .ex             (ex),
      .state          (state),
      .epu_dout       (epu_dout),
      .epu_dout_valid (epu_dout_valid),
      .commit         (commit)
   );

   // Next values and flush
   epu_commit u_commit
   (
      .clk           (clk),
      .reset         (reset),
      .commit        (commit),
      .state         (state),
      .s2i_ealign    (s2i_ealign),
      .p_ce_s2       (p_ce_s2),
      .s2i_vaddr     (s2i_vaddr),
      .wr            (wr),
      .exc_flush     (exc_flush),
      .exc_flush_tgt (exc_flush_tgt)
   );

   epu_msr_file u_msr_file
   (
      .clk   (clk),
      .reset (reset),
      .wr    (wr),
      .state (state)
   );

endmodule

`default_nettype wire

//--- tb/epu_tb.sv
// Random stimulus from a fixed seed; p_ce_s2 held high, s2i_ealign pulsed only with an empty entry
`timescale 1ns/1ps
`default_nettype none

module epu_tb;
   import epu_pkg::*;

   localparam logic [5:0] OP_NONE = 6'b000000;
   localparam logic [5:0] OP_RD   = 6'b100000;
   localparam logic [5:0] OP_WR   = 6'b010000;
   localparam logic [5:0] OP_ERET = 6'b001000;
   localparam logic [5:0] OP_SYS  = 6'b000100;
   localparam logic [5:0] OP_INSN = 6'b000010;
   localparam logic [5:0] OP_IRQ  = 6'b000001;
   localparam int         STALL_LIMIT = 16;
   localparam int         WAIT_LIMIT  = 8;

   logic            clk;
   logic            reset;
   logic            flush_s1;
   logic            p_ce_s1;
   logic            p_ce_s2;
   ex_req_t         ex;
   logic            s2i_ealign;
   logic [AW-1:0]   s2i_vaddr;
   logic [DW-1:0]   epu_dout;
   logic            epu_dout_valid;
   logic            exc_flush;
   logic [PC_W-1:0] exc_flush_tgt;

   // Reference copy of the MSRs and of the commit entry
   logic [DW-1:0]   m_psr;
   logic [DW-1:0]   m_epsr;
   logic [DW-1:0]   m_epc;
   logic [DW-1:0]   m_elsa;
   logic [DW-1:0]   m_sr [SR_NUM];
   epu_commit_t     m_ent;
   logic            m_ent_q;
   logic            seen_flush;

   int checks;
   int errors;
   int tests;
   int tests_failed;
   int err_mark;

   epu_top u_epu_top
   (
      .clk            (clk),
      .reset          (reset),
      .flush_s1       (flush_s1),
      .p_ce_s1        (p_ce_s1),
      .p_ce_s2        (p_ce_s2),
      .ex             (ex),
      .s2i_ealign     (s2i_ealign),
      .s2i_vaddr      (s2i_vaddr),
      .epu_dout       (epu_dout),
      .epu_dout_valid (epu_dout_valid),
      .exc_flush      (exc_flush),
      .exc_flush_tgt  (exc_flush_tgt)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #10 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [DW-1:0] got,
                              input logic [DW-1:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic stop_on_timeout(input string why);
      $display("%0t timeout: %s", $time, why);
      $display("TEST FAILED");
      $finish;
   endtask

   // MSR address split at random between operand one and the immediate
   function automatic ex_req_t make_req(input logic [5:0] opc, input logic [3:0] bank,
                                        input int bitpos, input logic [DW-1:0] wdata);
      ex_req_t       r;
      logic [DW-1:0] a;
      a       = {19'b0, bank, 9'b0} | (32'd1 << bitpos);
      r.valid = 1'b1;
      r.pc    = PC_W'($urandom);
      r.npc   = r.pc + 1'b1;
      r.opc   = opc;
      if ($urandom_range(1) == 1)
      begin
         r.operand1 = a | ($urandom & 32'hffff_e000);
         r.imm      = $urandom & 32'hffff_8000;
      end
      else
      begin
         r.operand1 = $urandom & 32'hffff_e000;
         r.imm      = a | ($urandom & 32'hffff_8000);
      end
      r.operand2 = wdata;
      return r;
   endfunction

   function automatic ex_req_t idle_req();
      ex_req_t r;
      r       = make_req(OP_NONE, 4'd0, 0, $urandom);
      r.valid = 1'b0;
      return r;
   endfunction

   // One clock of stimulus, output checks and model update
   task automatic drive_cycle(input ex_req_t req, input logic fl, input logic pce1,
                              input logic ea, input logic [AW-1:0] va);
      logic [DW-1:0]   addr;
      logic [3:0]      bank;
      logic [8:0]      off;
      logic            live;
      logic            hit;
      logic            ent;
      logic            exp_valid;
      logic            exp_flush;
      logic [DW-1:0]   exp_dout;
      logic [PC_W-1:0] exp_tgt;
      logic [DW-1:0]   old_psr;
      logic [DW-1:0]   old_epsr;
      epu_commit_t     nxt;
      ex         = req;
      flush_s1   = fl;
      p_ce_s1    = pce1;
      s2i_ealign = ea;
      s2i_vaddr  = va;
      #8;
      addr     = req.operand1 | {17'b0, req.imm[14:0]};
      bank     = addr[12:9];
      off      = addr[8:0];
      live     = req.valid & ~fl;
      exp_dout = '0;
      hit      = 1'b0;
      if (bank == BANK_PS)
      begin
         if (off[OFF_PSR])
            exp_dout = m_psr;
         else if (off[OFF_CPUID])
            exp_dout = CPUID_VAL;
         else if (off[OFF_EPSR])
            exp_dout = m_epsr;
         else if (off[OFF_EPC])
            exp_dout = m_epc;
         else if (off[OFF_ELSA])
            exp_dout = m_elsa;
         else if (off[OFF_COREID])
            exp_dout = COREID_VAL;
      end
      else if (bank == BANK_SR)
      begin
         for (int i = 0; i < SR_NUM; i++)
         begin
            if (off[i] && !hit)
            begin
               exp_dout = m_sr[i];
               hit      = 1'b1;
            end
         end
      end
      exp_valid = live & req.opc.rmsr;
      check_value("epu_dout_valid", 32'(epu_dout_valid), 32'(exp_valid));
      if (exp_valid)
         check_value("epu_dout", epu_dout, exp_dout);

      // Stage two works on the entry loaded at the last edge
      exp_flush = p_ce_s2 & (m_ent.eret | m_ent.esyscall | m_ent.einsn | m_ent.eirq |
                             m_ent.psr_refetch | ea);
      check_value("exc_flush", 32'(exc_flush), 32'(exp_flush));
      if (exc_flush)
         seen_flush = 1'b1;
      if (exp_flush)
      begin
         if (m_ent.esyscall)
            exp_tgt = VEC_ESYSCALL[AW-1:2];
         else if (m_ent.einsn)
            exp_tgt = VEC_EINSN[AW-1:2];
         else if (m_ent.eirq)
            exp_tgt = VEC_EIRQ[AW-1:2];
         else if (ea)
            exp_tgt = VEC_EALIGN[AW-1:2];
         else if (m_ent.psr_refetch)
            exp_tgt = m_ent.npc;
         else
            exp_tgt = m_epc[AW-1:2];
         check_value("exc_flush_tgt", 32'(exc_flush_tgt), 32'(exp_tgt));
      end

      ent      = m_ent.esyscall | m_ent.einsn | m_ent.eirq | ea;
      old_psr  = m_psr;
      old_epsr = m_epsr;
      // PSR keeps bits 9..4; entry sets rm and clears ire, imme, dmme
      if (m_ent.we_psr)
         m_psr = m_ent.wdat.raw & 32'h0000_03f0;
      else if (m_ent.eret)
         m_psr = (old_psr & ~32'h0000_00f0) | (old_epsr & 32'h0000_00f0);
      else if (ent)
         m_psr = (old_psr | 32'h0000_0010) & ~32'h0000_00e0;
      if (m_ent.we_epsr)
         m_epsr = m_ent.wdat.raw & 32'h0000_03ff;
      else if (ent && !m_ent_q)
         m_epsr = old_psr;
      if (m_ent.we_epc)
         m_epc = m_ent.wdat.raw;
      else if (m_ent.esyscall)
         m_epc = {m_ent.npc, 2'b00};
      else if (ent)
         m_epc = {m_ent.epc, 2'b00};
      if (m_ent.einsn)
         m_elsa = {m_ent.epc, 2'b00};
      else if (ea)
         m_elsa = va;
      else if (m_ent.we_elsa)
         m_elsa = m_ent.wdat.raw;
      for (int i = 0; i < SR_NUM; i++)
      begin
         if (m_ent.we_sr && m_ent.sr_off[i])
            m_sr[i] = m_ent.wdat.raw;
      end
      m_ent_q = ent;

      if (pce1 || fl)
      begin
         nxt          = '0;
         nxt.eret     = live & req.opc.eret;
         nxt.esyscall = live & req.opc.esyscall;
         nxt.einsn    = live & req.opc.einsn;
         nxt.eirq     = live & req.opc.eirq;
         if (live && req.opc.wmsr && bank == BANK_PS)
         begin
            nxt.we_psr  = off[OFF_PSR];
            nxt.we_epsr = off[OFF_EPSR];
            nxt.we_epc  = off[OFF_EPC];
            nxt.we_elsa = off[OFF_ELSA];
         end
         nxt.we_sr       = live & req.opc.wmsr & (bank == BANK_SR);
         nxt.psr_refetch = nxt.we_psr;
         nxt.sr_off      = off[SR_NUM-1:0];
         nxt.wdat.raw    = req.operand2;
         nxt.epc         = req.pc;
         nxt.npc         = req.npc;
         m_ent           = nxt;
      end
      @(posedge clk);
      #2;
   endtask

   // Holds the slot while stage one is stalled
   task automatic issue(input ex_req_t req);
      logic go;
      int   n;
      go = 1'b0;
      n  = 0;
      while (!go)
      begin
         if (n == STALL_LIMIT)
            stop_on_timeout("stage one never accepted the instruction");
         go = ($urandom_range(7) != 0);
         drive_cycle(req, 1'b0, go, 1'b0, '0);
         n++;
      end
   endtask

   task automatic wait_for_flush(input string what);
      int n;
      n          = 0;
      seen_flush = 1'b0;
      while (!seen_flush)
      begin
         if (n == WAIT_LIMIT)
            stop_on_timeout({"no exc_flush after ", what});
         issue(idle_req());
         n++;
      end
   endtask

   task automatic pulse_ealign(input logic [AW-1:0] va);
      int n;
      n = 0;
      while (m_ent.eret | m_ent.esyscall | m_ent.einsn | m_ent.eirq | m_ent.psr_refetch)
      begin
         if (n == WAIT_LIMIT)
            stop_on_timeout("commit entry never drained before the EALIGN pulse");
         issue(idle_req());
         n++;
      end
      drive_cycle(idle_req(), 1'b0, 1'b1, 1'b1, va);
      issue(idle_req());
   endtask

   task automatic read_all_msrs();
      issue(idle_req());
      issue(make_req(OP_RD, BANK_PS, OFF_PSR, 0));
      issue(make_req(OP_RD, BANK_PS, OFF_EPSR, 0));
      issue(make_req(OP_RD, BANK_PS, OFF_EPC, 0));
      issue(make_req(OP_RD, BANK_PS, OFF_ELSA, 0));
      for (int i = 0; i < SR_NUM; i++)
         issue(make_req(OP_RD, BANK_SR, i, 0));
   endtask

   task automatic begin_test();
      err_mark = errors;
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors == err_mark)
         $display("test %s: ok", name);
      else
      begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - err_mark);
      end
   endtask

   initial
   begin
      int            sel;
      int            bitpos;
      logic [3:0]    bank;
      logic [5:0]    op;
      void'($urandom(32'h186dd0f8));
      reset      = 1'b1;
      flush_s1   = 1'b0;
      p_ce_s1    = 1'b1;
      p_ce_s2    = 1'b1;
      ex         = idle_req();
      s2i_ealign = 1'b0;
      s2i_vaddr  = '0;
      checks     = 0;
      errors     = 0;
      tests      = 0;
      tests_failed = 0;
      // Reset values: rm set in PSR, everything else zero
      m_psr   = 32'h0000_0010;
      m_epsr  = '0;
      m_epc   = '0;
      m_elsa  = '0;
      m_ent   = '0;
      m_ent_q = 1'b0;
      for (int i = 0; i < SR_NUM; i++)
         m_sr[i] = '0;
      repeat (8) @(posedge clk);
      #2;
      reset = 1'b0;

      begin_test();
      issue(make_req(OP_RD, BANK_PS, OFF_PSR, 0));
      issue(make_req(OP_RD, BANK_PS, OFF_CPUID, 0));
      issue(make_req(OP_RD, BANK_PS, OFF_COREID, 0));
      issue(make_req(OP_RD, 4'd3, 0, 0));
      read_all_msrs();
      end_test("reset values");

      begin_test();
      for (int k = 0; k < 24; k++)
      begin
         sel = $urandom_range(6);
         if (sel < SR_NUM)
         begin
            bank   = BANK_SR;
            bitpos = sel;
         end
         else
         begin
            bank   = BANK_PS;
            bitpos = (sel == 4) ? OFF_EPC : (sel == 5) ? OFF_EPSR : OFF_ELSA;
         end
         issue(make_req(OP_WR, bank, bitpos, $urandom));
         issue(idle_req());
         issue(make_req(OP_RD, bank, bitpos, 0));
      end
      end_test("msr write and read");

      begin_test();
      for (int k = 0; k < 6; k++)
      begin
         issue(make_req(OP_WR, BANK_PS, OFF_PSR, $urandom));
         wait_for_flush("psr write");
         op = (k % 3 == 0) ? OP_SYS : (k % 3 == 1) ? OP_INSN : OP_IRQ;
         issue(make_req(op, 4'd1, 0, $urandom));
         wait_for_flush("exception");
         read_all_msrs();
      end
      end_test("exception entry");

      begin_test();
      for (int k = 0; k < 4; k++)
      begin
         issue(make_req(OP_WR, BANK_PS, OFF_EPSR, $urandom));
         issue(make_req(OP_WR, BANK_PS, OFF_EPC, $urandom));
         issue(idle_req());
         issue(make_req(OP_ERET, 4'd1, 0, $urandom));
         wait_for_flush("eret");
         read_all_msrs();
      end
      end_test("eret");

      begin_test();
      for (int k = 0; k < 4; k++)
      begin
         issue(make_req(OP_WR, BANK_PS, OFF_PSR, $urandom));
         wait_for_flush("psr write");
         issue(make_req(OP_RD, BANK_PS, OFF_PSR, 0));
         pulse_ealign($urandom);
         read_all_msrs();
      end
      end_test("psr refetch and ealign");

      begin_test();
      for (int k = 0; k < 16; k++)
      begin
         case ($urandom_range(4))
            0: drive_cycle(make_req(OP_WR, BANK_SR, $urandom_range(3), $urandom),
                           1'b1, 1'(($urandom_range(1))), 1'b0, '0);
            1: drive_cycle(make_req(OP_WR, BANK_PS, OFF_EPC, $urandom),
                           1'b1, 1'(($urandom_range(1))), 1'b0, '0);
            2: drive_cycle(make_req(OP_WR, BANK_PS, OFF_PSR, $urandom),
                           1'b1, 1'(($urandom_range(1))), 1'b0, '0);
            3: drive_cycle(make_req(OP_SYS, 4'd1, 0, $urandom),
                           1'b1, 1'(($urandom_range(1))), 1'b0, '0);
            default: drive_cycle(make_req(OP_RD, BANK_PS, OFF_PSR, 0),
                                 1'b1, 1'(($urandom_range(1))), 1'b0, '0);
         endcase
      end
      read_all_msrs();
      end_test("flush_s1 squash");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests, tests_failed, checks, errors);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim.f
logic/epu_pkg.sv
logic/epu_stage1.sv
logic/epu_commit.sv
logic/epu_msr_file.sv
logic/epu_top.sv
tb/epu_tb.sv

//--- Bender.yml
package:
  name: epu

sources:
  - logic/epu_pkg.sv
  - logic/epu_stage1.sv
  - logic/epu_commit.sv
  - logic/epu_msr_file.sv
  - logic/epu_top.sv
  - target: simulation
    files:
      - tb/epu_tb.sv
